// File: verilog/cpu_types_pkg.sv
// CPU-wide data word type and the data address layout
`default_nettype none

package cpu_types_pkg;

  localparam int WORD_W = 32;

  // Datapath and memory bus word
  typedef logic [WORD_W-1:0] word_t;

  // Data address split for the cache
  // Tag and index select the block, blkoff picks one of its two words
  typedef struct packed {
    logic [25:0] tag;
    logic [2:0]  idx;
    logic        blkoff;
    logic [1:0]  bytoff;  // Always zero for word accesses
  } dcachef_t;

  // One address, readable as a raw word or as cache fields
  typedef union packed {
    word_t    raw;
    dcachef_t f;
  } daddr_u;

endpackage

`default_nettype wire

// File: verilog/dcache_pkg.sv
// Cache geometry and the structs passed between the cache blocks
`default_nettype none

package dcache_pkg;

  localparam int SETS      = 8;
  localparam int WAYS      = 2;
  localparam int TAG_W     = 26;
  localparam int BLK_WORDS = 2;
  localparam int IDX_W     = $clog2(SETS);

  // Address of the hit minus miss statistic written at the end of a flush
  localparam cpu_types_pkg::word_t STAT_ADDR = 32'h0000_3100;

  // Contents of one block
  typedef cpu_types_pkg::word_t [BLK_WORDS-1:0] blk_t;

  // Datapath side
  typedef struct packed {
    logic                  ren;
    logic                  wen;
    logic                  halt;
    cpu_types_pkg::daddr_u addr;
    cpu_types_pkg::word_t  store;
  } dp_req_t;

  typedef struct packed {
    logic                 dhit;
    logic                 flushed;
    cpu_types_pkg::word_t load;
  } dp_rsp_t;

  // Memory bus side
  typedef struct packed {
    logic                 ren;
    logic                 wen;
    cpu_types_pkg::word_t addr;
    cpu_types_pkg::word_t store;
  } mem_req_t;

  typedef struct packed {
    logic                 dwait;
    cpu_types_pkg::word_t load;
  } mem_rsp_t;

  // Controller to block sequencer
  typedef struct packed {
    logic                 go;
    logic                 write;   // 1 write-back, 0 fill
    logic                 single;  // One beat only
    cpu_types_pkg::word_t base;
    blk_t                 data;
  } blk_cmd_t;

  typedef struct packed {
    logic done;  // Pulses as the last beat completes
    blk_t data;
  } blk_rsp_t;

  // Controller to tag store
  typedef struct packed {
    logic             en;
    logic             way;
    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] tag;
    logic             valid;
    logic             dirty;
    logic             lru_en;
    logic             lru_val;
  } tag_upd_t;

  // Tag store lookup result
  typedef struct packed {
    logic             hit;
    logic             hit_way;
    logic             victim_way;
    logic             victim_dirty;
    logic [TAG_W-1:0] victim_tag;
  } lookup_t;

endpackage

`default_nettype wire

// File: verilog/dcache_tag_store.sv
// Tag, valid, dirty and LRU arrays with two-way lookup and a flush read port
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_store (
  input  logic                         CLK,
  input  logic                         nRST,
  input  cpu_types_pkg::daddr_u        addr,
  input  dcache_pkg::tag_upd_t         upd,
  input  logic [dcache_pkg::IDX_W-1:0] flush_idx,
  input  logic                         flush_way,
  output dcache_pkg::lookup_t          lookup,
  output logic                         flush_dirty,
  output logic [dcache_pkg::TAG_W-1:0] flush_tag
);

  logic [dcache_pkg::TAG_W-1:0] tag_q [dcache_pkg::WAYS][dcache_pkg::SETS];
  logic [dcache_pkg::WAYS-1:0][dcache_pkg::SETS-1:0] valid_q;
  logic [dcache_pkg::WAYS-1:0][dcache_pkg::SETS-1:0] dirty_q;
  logic [dcache_pkg::SETS-1:0] lru_q;  // Way to replace next, per set

  logic [dcache_pkg::IDX_W-1:0] idx;
  logic hit0;
  logic hit1;
  logic vway;

  assign idx  = addr.f.idx;
  assign hit0 = valid_q[0][idx] && (tag_q[0][idx] == addr.f.tag);
  assign hit1 = valid_q[1][idx] && (tag_q[1][idx] == addr.f.tag);
  assign vway = lru_q[idx];

  always_comb
  begin
    lookup.hit          = hit0 | hit1;
    lookup.hit_way      = hit1;  // Way 1 when it hits, else way 0
    lookup.victim_way   = vway;
    lookup.victim_dirty = valid_q[vway][idx] & dirty_q[vway][idx];
    lookup.victim_tag   = tag_q[vway][idx];
  end

  // Second read port, walked by the flush
  assign flush_dirty = valid_q[flush_way][flush_idx] & dirty_q[flush_way][flush_idx];
  assign flush_tag   = tag_q[flush_way][flush_idx];

  always_ff @(posedge CLK)
  begin
    if (upd.en)
      tag_q[upd.way][upd.idx] <= upd.tag;
  end

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      valid_q <= '0;
      dirty_q <= '0;
      lru_q   <= '0;
    end
    else
    begin
      if (upd.en)
      begin
        valid_q[upd.way][upd.idx] <= upd.valid;
        dirty_q[upd.way][upd.idx] <= upd.dirty;
      end
      if (upd.lru_en)
        lru_q[upd.idx] <= upd.lru_val;
    end
  end

  // A tag is only installed into the victim way after a miss, so
  // both ways of one set never hold the same valid tag
  a_single_way_hit: assert property (
    @(posedge CLK) disable iff (!nRST)
    !(hit0 && hit1)
  );

endmodule

`default_nettype wire

// File: verilog/dcache_ctrl.sv
// Cache FSM with data array, flush walk and hit/miss counters
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
  input  logic                         CLK,
  input  logic                         nRST,
  input  dcache_pkg::dp_req_t          req,
  output dcache_pkg::dp_rsp_t          rsp,
  input  dcache_pkg::lookup_t          lookup,
  output dcache_pkg::tag_upd_t         upd,
  output logic [dcache_pkg::IDX_W-1:0] flush_idx,
  output logic                         flush_way,
  input  logic                         flush_dirty,
  input  logic [dcache_pkg::TAG_W-1:0] flush_tag,
  output dcache_pkg::blk_cmd_t         blk_cmd,
  input  dcache_pkg::blk_rsp_t         blk_rsp
);

  typedef enum logic [2:0] {
    IDLE,
    WRITEBACK,
    FILL,
    INSTALL,
    FLUSH_SCAN,
    FLUSH_WB,
    STAT,
    HALTED
  } state_t;

  state_t state_q, state_d;

  dcache_pkg::blk_t data_q [dcache_pkg::WAYS][dcache_pkg::SETS];

  cpu_types_pkg::word_t hit_cnt_q, hit_cnt_d;
  cpu_types_pkg::word_t miss_cnt_q, miss_cnt_d;

  logic vway_q, vway_d;  // Way chosen on the miss
  logic [dcache_pkg::IDX_W-1:0] walk_idx_q, walk_idx_d;
  logic walk_way_q, walk_way_d;

  logic data_we;
  logic data_way;
  dcache_pkg::blk_t data_wr;

  logic [dcache_pkg::IDX_W-1:0] idx;
  logic blkoff;
  logic access;
  logic walk_last;

  assign idx       = req.addr.f.idx;
  assign blkoff    = req.addr.f.blkoff;
  assign access    = req.ren | req.wen;
  assign walk_last = walk_way_q && (&walk_idx_q);  // Last set of way 1

  assign flush_idx = walk_idx_q;
  assign flush_way = walk_way_q;

  always_comb
  begin
    state_d    = state_q;
    hit_cnt_d  = hit_cnt_q;
    miss_cnt_d = miss_cnt_q;
    vway_d     = vway_q;
    walk_idx_d = walk_idx_q;
    walk_way_d = walk_way_q;

    rsp     = '0;
    upd     = '0;
    upd.idx = idx;
    upd.tag = req.addr.f.tag;
    blk_cmd = '0;

    data_we  = 1'b0;
    data_way = lookup.hit_way;
    data_wr  = data_q[lookup.hit_way][idx];

    case (state_q)
      IDLE:
      begin
        if (access && lookup.hit)
        begin
          rsp.dhit    = 1'b1;
          rsp.load    = data_q[lookup.hit_way][idx][blkoff];
          hit_cnt_d   = hit_cnt_q + 1'b1;
          upd.lru_en  = 1'b1;
          upd.lru_val = ~lookup.hit_way;  // Other way becomes the victim
          if (!req.ren)
          begin
            data_we         = 1'b1;
            data_wr[blkoff] = req.store;
            upd.en          = 1'b1;
            upd.way         = lookup.hit_way;
            upd.valid       = 1'b1;
            upd.dirty       = 1'b1;
          end
        end
        else if (access)
        begin
          miss_cnt_d = miss_cnt_q + 1'b1;
          vway_d     = lookup.victim_way;
          if (lookup.victim_dirty)
            state_d = WRITEBACK;
          else if (req.ren)
            state_d = FILL;
          else
            state_d = INSTALL;  // Write miss allocates without a fetch
        end
        else if (req.halt)
        begin
          walk_idx_d = '0;
          walk_way_d = 1'b0;
          state_d    = FLUSH_SCAN;
        end
      end

      WRITEBACK:
      begin
        // Victim goes back at its own tag and the request's index
        blk_cmd.go    = 1'b1;
        blk_cmd.write = 1'b1;
        blk_cmd.base  = {lookup.victim_tag, idx, 3'b000};
        blk_cmd.data  = data_q[vway_q][idx];
        if (blk_rsp.done)
          state_d = req.ren ? FILL : INSTALL;
      end

      FILL:
      begin
        blk_cmd.go   = 1'b1;
        blk_cmd.base = {req.addr.raw[31:3], 3'b000};
        if (blk_rsp.done)
          state_d = INSTALL;
      end

      INSTALL:
      begin
        upd.en    = 1'b1;
        upd.way   = vway_q;
        upd.valid = 1'b1;
        upd.dirty = 1'b0;  // Next IDLE cycle hits and marks a write dirty
        if (req.ren)
        begin
          data_we  = 1'b1;
          data_way = vway_q;
          data_wr  = blk_rsp.data;
        end
        state_d = IDLE;
      end

      FLUSH_SCAN:
      begin
        if (flush_dirty)
          state_d = FLUSH_WB;
        else
        begin
          walk_idx_d = walk_idx_q + 1'b1;
          if (&walk_idx_q)
            walk_way_d = 1'b1;
          if (walk_last)
            state_d = STAT;
        end
      end

      FLUSH_WB:
      begin
        blk_cmd.go    = 1'b1;
        blk_cmd.write = 1'b1;
        blk_cmd.base  = {flush_tag, walk_idx_q, 3'b000};
        blk_cmd.data  = data_q[walk_way_q][walk_idx_q];
        if (blk_rsp.done)
        begin
          walk_idx_d = walk_idx_q + 1'b1;
          if (&walk_idx_q)
            walk_way_d = 1'b1;
          state_d = walk_last ? STAT : FLUSH_SCAN;
        end
      end

      STAT:
      begin
        blk_cmd.go      = 1'b1;
        blk_cmd.write   = 1'b1;
        blk_cmd.single  = 1'b1;
        blk_cmd.base    = dcache_pkg::STAT_ADDR;
        blk_cmd.data[0] = hit_cnt_q - miss_cnt_q;
        if (blk_rsp.done)
          state_d = HALTED;
      end

      HALTED:
        rsp.flushed = 1'b1;  // Held until reset

      default:
        state_d = IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      state_q    <= IDLE;
      hit_cnt_q  <= '0;
      miss_cnt_q <= '0;
      vway_q     <= 1'b0;
      walk_idx_q <= '0;
      walk_way_q <= 1'b0;
    end
    else
    begin
      state_q    <= state_d;
      hit_cnt_q  <= hit_cnt_d;
      miss_cnt_q <= miss_cnt_d;
      vway_q     <= vway_d;
      walk_idx_q <= walk_idx_d;
      walk_way_q <= walk_way_d;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (data_we)
      data_q[data_way][idx] <= data_wr;
  end

  // The sequencer reads the command fields beat by beat, so they
  // may not move until it reports done
  a_cmd_stable: assert property (
    @(posedge CLK) disable iff (!nRST)
    (blk_cmd.go && !blk_rsp.done) |=> $stable(blk_cmd)
  );

endmodule

`default_nettype wire

// File: verilog/dcache_mem_port.sv
// Two-beat block fill and write-back sequencer on the memory bus
`timescale 1ns/1ps
`default_nettype none

module dcache_mem_port (
  input  logic                 CLK,
  input  logic                 nRST,
  input  dcache_pkg::blk_cmd_t cmd,
  output dcache_pkg::blk_rsp_t rsp,
  output dcache_pkg::mem_req_t mreq,
  input  dcache_pkg::mem_rsp_t mrsp
);

  typedef enum logic [1:0] {
    MP_IDLE,
    MP_BEAT0,
    MP_BEAT1
  } mp_state_t;

  mp_state_t state_q, state_d;

  dcache_pkg::blk_t fill_q;  // Words captured during a fill

  logic busy;
  logic beat;      // Word of the block on the bus
  logic beat_ok;   // Current beat completes this cycle
  logic last_beat;

  assign busy      = (state_q != MP_IDLE);
  assign beat      = (state_q == MP_BEAT1);
  assign beat_ok   = busy && !mrsp.dwait;
  assign last_beat = beat || cmd.single;

  always_comb
  begin
    mreq    = '0;
    state_d = state_q;
    if (busy)
    begin
      mreq.ren   = !cmd.write;
      mreq.wen   = cmd.write;
      mreq.addr  = cmd.base + {29'd0, beat, 2'b00};  // base, then base+4
      mreq.store = cmd.data[beat];
    end

    case (state_q)
      MP_IDLE:
        if (cmd.go)
          state_d = MP_BEAT0;
      MP_BEAT0:
        if (!mrsp.dwait)
          state_d = cmd.single ? MP_IDLE : MP_BEAT1;
      MP_BEAT1:
        if (!mrsp.dwait)
          state_d = MP_IDLE;
      default:
        state_d = MP_IDLE;
    endcase

    rsp.done = beat_ok && last_beat;
    rsp.data = fill_q;
  end

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      state_q <= MP_IDLE;
    else
      state_q <= state_d;
  end

  always_ff @(posedge CLK)
  begin
    if (beat_ok && !cmd.write)
      fill_q[beat] <= mrsp.load;
  end

  // A stalled beat keeps its enables, address and data on the bus
  a_hold_on_wait: assert property (
    @(posedge CLK) disable iff (!nRST)
    ((mreq.ren || mreq.wen) && mrsp.dwait) |=> $stable(mreq)
  );

endmodule

`default_nettype wire

// File: verilog/dcache_top.sv
// Data cache top level with tag store, controller and memory sequencer
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
  input  logic                 CLK,
  input  logic                 nRST,
  input  dcache_pkg::dp_req_t  dp_req,
  output dcache_pkg::dp_rsp_t  dp_rsp,
  output dcache_pkg::mem_req_t mem_req,
  input  dcache_pkg::mem_rsp_t mem_rsp
);

  dcache_pkg::lookup_t          lookup;
  dcache_pkg::tag_upd_t         upd;
  dcache_pkg::blk_cmd_t         blk_cmd;
  dcache_pkg::blk_rsp_t         blk_rsp;
  logic [dcache_pkg::IDX_W-1:0] flush_idx;
  logic                         flush_way;
  logic                         flush_dirty;
  logic [dcache_pkg::TAG_W-1:0] flush_tag;

  dcache_tag_store u_tag_store (
    .CLK         (CLK),
    .nRST        (nRST),
    .addr        (dp_req.addr),
    .upd         (upd),
    .flush_idx   (flush_idx),
    .flush_way   (flush_way),
    .lookup      (lookup),
    .flush_dirty (flush_dirty),
    .flush_tag   (flush_tag)
  );

  dcache_ctrl u_ctrl (
    .CLK         (CLK),
    .nRST        (nRST),
    .req         (dp_req),
    .rsp         (dp_rsp),
    .lookup      (lookup),
    .upd         (upd),
    .flush_idx   (flush_idx),
    .flush_way   (flush_way),
    .flush_dirty (flush_dirty),
    .flush_tag   (flush_tag),
    .blk_cmd     (blk_cmd),
    .blk_rsp     (blk_rsp)
  );

  dcache_mem_port u_mem_port (
    .CLK  (CLK),
    .nRST (nRST),
    .cmd  (blk_cmd),
    .rsp  (blk_rsp),
    .mreq (mem_req),
    .mrsp (mem_rsp)
  );

endmodule

`default_nettype wire

// File: dv/mem_model.sv
// Word-addressed memory with externally driven dwait stalls
`timescale 1ns/1ps
`default_nettype none

module mem_model (
  input  logic                 CLK,
  input  dcache_pkg::mem_req_t req,
  input  logic                 stall,  // Hold the current beat when high
  output dcache_pkg::mem_rsp_t rsp
);

  localparam int DEPTH = 4096;

  // Filled by the testbench before reset is released
  cpu_types_pkg::word_t words [DEPTH];

  logic [11:0] widx;
  logic        active;

  assign widx   = req.addr[13:2];
  assign active = req.ren | req.wen;

  always_comb
  begin
    rsp.dwait = active & stall;
    rsp.load  = words[widx];  // Read data valid whenever dwait is low
  end

  always @(posedge CLK)
  begin
    if (req.wen && !rsp.dwait)
      words[widx] <= req.store;
  end

endmodule

`default_nettype wire

// File: dv/tb_dcache_top.sv
// Testbench for the data cache with reference model, compare process and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_top;

  localparam int N_OPS     = 120;
  localparam int WD_CYCLES = (2 * N_OPS + 16) * 200 + 4000;  // Ops plus flush allowance
  localparam int STAT_IDX  = 32'h3100 >> 2;

  typedef struct packed {
    logic        hit;
    logic        wb;       // Dirty victim written back
    logic [31:0] wb_addr;
  } ref_res_t;

  logic CLK;
  logic nRST;
  logic stall;
  dcache_pkg::dp_req_t  dp_req;
  dcache_pkg::dp_rsp_t  dp_rsp;
  dcache_pkg::mem_req_t mem_req;
  dcache_pkg::mem_rsp_t mem_rsp;

  // Reference cache state
  logic [25:0] m_tag [2][8];
  logic        m_valid [2][8];
  logic        m_dirty [2][8];
  logic        m_lru [8];
  logic [31:0] hits;
  logic [31:0] misses;
  logic [31:0] shadow [4096];  // Expected memory image

  logic [31:0] stall_rng;
  logic [31:0] addr_rng;
  logic        first_cycle;
  logic        exp_hit;
  int          errors;
  int          checks;

  dcache_top dut (
    .CLK     (CLK),
    .nRST    (nRST),
    .dp_req  (dp_req),
    .dp_rsp  (dp_rsp),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

  mem_model mem (
    .CLK   (CLK),
    .req   (mem_req),
    .stall (stall),
    .rsp   (mem_rsp)
  );

  always #2 CLK = ~CLK;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Initial memory contents depend on every address bit
  function automatic logic [31:0] fill_pattern(input int i);
    return (i * 32'h9E37_79B9) ^ 32'h1357_0000;
  endfunction

  // Reference cache with LRU victim, write allocate and a replayed hit after each miss
  function ref_res_t ref_access(input logic wr, input logic [31:0] addr);
    ref_res_t    r;
    logic [25:0] tag;
    logic [2:0]  idx;
    logic        w;
    r   = '0;
    w   = 1'b0;
    tag = addr[31:6];
    idx = addr[5:3];
    if (m_valid[0][idx] && m_tag[0][idx] == tag)
      r.hit = 1'b1;
    else if (m_valid[1][idx] && m_tag[1][idx] == tag)
    begin
      r.hit = 1'b1;
      w     = 1'b1;
    end
    if (!r.hit)
    begin
      misses = misses + 1;
      w      = m_lru[idx];
      if (m_valid[w][idx] && m_dirty[w][idx])
      begin
        r.wb      = 1'b1;
        r.wb_addr = {m_tag[w][idx], idx, 3'b000};
      end
      m_tag[w][idx]   = tag;
      m_valid[w][idx] = 1'b1;
      m_dirty[w][idx] = 1'b0;
    end
    hits       = hits + 1;  // Miss is completed by a hit in IDLE
    m_lru[idx] = ~w;
    if (wr)
      m_dirty[w][idx] = 1'b1;
    return r;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks = checks + 1;
    if (got !== exp)
    begin
      errors = errors + 1;
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic do_access(input logic wr, input logic [31:0] addr, input logic [31:0] data);
    ref_res_t r;
    r = ref_access(wr, addr);
    if (wr)
      shadow[addr[13:2]] = data;
    exp_hit          = r.hit;
    dp_req.ren       = !wr;
    dp_req.wen       = wr;
    dp_req.addr.raw  = addr;
    dp_req.store     = data;
    first_cycle      = 1'b1;
    do
      @(negedge CLK);
    while (!dp_rsp.dhit);
    @(posedge CLK);
    #1;
    dp_req.ren = 1'b0;
    dp_req.wen = 1'b0;
    if (r.wb)
    begin
      check("wb_word0", mem.words[r.wb_addr[13:2]], shadow[r.wb_addr[13:2]]);
      check("wb_word1", mem.words[r.wb_addr[13:2] + 1], shadow[r.wb_addr[13:2] + 1]);
    end
  endtask

  // Writes both words of a block so that no half-written block is written back
  task automatic write_block(input logic [31:0] base, input logic [31:0] data);
    do_access(1'b1, base, data);
    do_access(1'b1, base + 32'd4, ~data);
  endtask

  // Compare process
  always @(negedge CLK)
  begin
    if (first_cycle)
    begin
      check("dhit", {31'd0, dp_rsp.dhit}, {31'd0, exp_hit});
      first_cycle = 1'b0;
    end
    if (dp_req.ren && dp_rsp.dhit)
      check("load", dp_rsp.load, shadow[dp_req.addr.raw[13:2]]);
  end

  // Memory stalls
  always @(posedge CLK)
  begin
    #1;
    stall_rng = xorshift(stall_rng);
    stall     = (stall_rng[1:0] == 2'b00);
  end

  initial
  begin
    repeat (WD_CYCLES) @(posedge CLK);
    $display("Timeout: the cache did not finish the tests in %0d cycles", WD_CYCLES);
    $display("sim failed");
    $finish;
  end

  initial
  begin
    int          i;
    int          n;
    logic [31:0] rnd;
    logic [31:0] a;
    CLK         = 1'b0;
    nRST        = 1'b0;
    stall       = 1'b0;
    dp_req      = '0;
    stall_rng   = 32'hdef1;
    addr_rng    = 32'hdef1;
    first_cycle = 1'b0;
    exp_hit     = 1'b0;
    errors      = 0;
    checks      = 0;
    hits        = '0;
    misses      = '0;
    for (i = 0; i < 8; i++)
    begin
      m_lru[i]      = 1'b0;
      m_valid[0][i] = 1'b0;
      m_valid[1][i] = 1'b0;
      m_dirty[0][i] = 1'b0;
      m_dirty[1][i] = 1'b0;
    end
    for (i = 0; i < 4096; i++)
    begin
      shadow[i]    = fill_pattern(i);
      mem.words[i] = fill_pattern(i);
    end

    repeat (8) @(posedge CLK);
    #1;
    nRST = 1'b1;
    repeat (2)
    begin
      @(negedge CLK);
      check("dhit", {31'd0, dp_rsp.dhit}, 32'd0);
      check("flushed", {31'd0, dp_rsp.flushed}, 32'd0);
      check("mem_ren", {31'd0, mem_req.ren}, 32'd0);
      check("mem_wen", {31'd0, mem_req.wen}, 32'd0);
    end
    @(posedge CLK);
    #1;

    // Three tags in set 5 force out a dirty block, then read it back
    write_block({26'd4, 3'd5, 3'b000}, 32'hA000_0004);
    write_block({26'd5, 3'd5, 3'b000}, 32'hA000_0005);
    write_block({26'd6, 3'd5, 3'b000}, 32'hA000_0006);
    do_access(1'b0, {26'd4, 3'd5, 3'b100}, 32'd0);

    for (n = 0; n < N_OPS; n++)
    begin
      addr_rng = xorshift(addr_rng);
      rnd      = addr_rng;
      a        = {24'd0, rnd[1:0], rnd[4:2], rnd[5], 2'b00};
      if (rnd[9:8] != 2'b00)
        do_access(1'b0, a, 32'd0);
      else
        write_block({a[31:3], 3'b000}, rnd);
    end

    dp_req.halt = 1'b1;
    do
      @(negedge CLK);
    while (!dp_rsp.flushed);

    for (i = 0; i < 4096; i++)
    begin
      if (i == STAT_IDX)
        check("stat", mem.words[i], hits - misses);
      else
        check("mem_image", mem.words[i], shadow[i]);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: dcache_top.f
verilog/cpu_types_pkg.sv
verilog/dcache_pkg.sv
verilog/dcache_tag_store.sv
verilog/dcache_ctrl.sv
verilog/dcache_mem_port.sv
verilog/dcache_top.sv
dv/mem_model.sv
dv/tb_dcache_top.sv

// File: run.sh
#!/bin/sh
# Build and run the data cache testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
  -f dcache_top.f --top-module tb_dcache_top -o sim_dcache
./obj_dir/sim_dcache > sim.log 2>&1 || true
cat sim.log

grep -q "^sim passed$" sim.log
